/* verilog/mulDefines.svh */
// Multiply unit widths, depths and credit totals
// Shared by the packages and the RTL modules of the multiply unit

`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand and result word
`define MUL_DATA_WIDTH 32
// cycles from request acceptance to queue write (at least 3)
`define MUL_PIPE_DEPTH 4
// result queue slots and the upstream credit total
`define MUL_QUEUE_DEPTH 8
// downstream credits held after reset
`define MUL_RSP_CREDITS 4
`define MUL_TAG_WIDTH 4

`endif

/* verilog/mulOpPkg.sv */
// Multiply operation types
// Operation encoding of the M-extension multiplies and the operand words

`default_nettype none

`include "mulDefines.svh"

package mulOpPkg;

    // same encoding as funct3[1:0] of the multiply instructions
    typedef enum logic [1:0] {
        opMul    = 2'b00,
        opMulh   = 2'b01,
        opMulhsu = 2'b10,
        opMulhu  = 2'b11
    } mulOpT;

    typedef logic [`MUL_DATA_WIDTH-1:0] mulDataT;

    // operand with one extra sign bit
    typedef logic signed [`MUL_DATA_WIDTH:0] mulExtT;

endpackage

`default_nettype wire

/* verilog/mulFlowPkg.sv */
// Multiply unit flow control types
// Tags, credit counters and the response record held in the result queue

`default_nettype none

`include "mulDefines.svh"

package mulFlowPkg;
    import mulOpPkg::*;

    typedef logic [`MUL_TAG_WIDTH-1:0] mulTagT;

    typedef logic [$clog2(`MUL_QUEUE_DEPTH + 1)-1:0] creditCntT;

    typedef struct packed {
        mulTagT  tag;
        mulDataT data;
    } mulRspT;

endpackage

`default_nettype wire

/* verilog/mulIssueIf.sv */
// Multiply issue interface
// Carries an accepted request from the control block to operand preparation

`timescale 1ns/1ps
`default_nettype none

interface mulIssueIf
    import mulOpPkg::*, mulFlowPkg::*;
();
    logic    valid;
    mulOpT   op;
    mulTagT  tag;
    mulDataT srcA;
    mulDataT srcB;

    modport issuer (output valid, output op, output tag, output srcA, output srcB);

    modport prep (input valid, input op, input tag, input srcA, input srcB);

endinterface

`default_nettype wire

/* verilog/mulOperandIf.sv */
// Multiply operand interface
// Carries extended operands and sideband into the multiply pipeline

`timescale 1ns/1ps
`default_nettype none

interface mulOperandIf
    import mulOpPkg::*, mulFlowPkg::*;
();
    logic   valid;
    mulTagT tag;
    // result comes from the upper word of the product
    logic   highHalf;
    mulExtT extA;
    mulExtT extB;

    modport source (output valid, output tag, output highHalf, output extA, output extB);

    modport sink (input valid, input tag, input highHalf, input extA, input extB);

endinterface

`default_nettype wire

/* verilog/mulOperandPrep.sv */
// Multiply operand preparation
// Extends both operands by one bit, signed or unsigned by operation,
// and registers them with valid and tag as the first pipeline stage

`timescale 1ns/1ps
`default_nettype none

`include "mulDefines.svh"

module mulOperandPrep
    import mulOpPkg::*;
(
    input wire logic   clk,
    input wire logic   rstN,
    mulIssueIf.prep    issue,
    mulOperandIf.source operand
);
    logic   signA;
    logic   signB;
    mulExtT extA;
    mulExtT extB;

    // srcA signed for MULH and MULHSU, srcB only for MULH
    always_comb begin
        signA = (issue.op == opMulh) || (issue.op == opMulhsu);
        signB = (issue.op == opMulh);
        extA = {signA & issue.srcA[`MUL_DATA_WIDTH-1], issue.srcA};
        extB = {signB & issue.srcB[`MUL_DATA_WIDTH-1], issue.srcB};
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            operand.valid <= 1'b0;
        end else begin
            operand.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        operand.tag      <= issue.tag;
        operand.highHalf <= (issue.op != opMul);
        operand.extA     <= extA;
        operand.extB     <= extB;
    end

endmodule

`default_nettype wire

/* verilog/mulPipelinedCore.sv */
// Pipelined signed 33x33 multiply
// Registers the product, carries it with valid, tag and half select
// through the remaining stages, and picks the result word at the end

`timescale 1ns/1ps
`default_nettype none

`include "mulDefines.svh"

module mulPipelinedCore
    import mulOpPkg::*, mulFlowPkg::*;
#(
    parameter int stageCount = `MUL_PIPE_DEPTH - 1
) (
    input wire logic  clk,
    input wire logic  rstN,
    mulOperandIf.sink operand,
    output logic      push,
    output mulRspT    pushData
);
    localparam int prodWidth = 2 * `MUL_DATA_WIDTH + 2;
    localparam int last = stageCount - 1;

    if (stageCount < 2) begin : gStageCheck
        $error("mulPipelinedCore needs stageCount of 2 or more");
    end

    logic signed [prodWidth-1:0] product;
    logic signed [prodWidth-1:0] prodReg [stageCount];
    mulTagT                      tagReg [stageCount];
    logic [stageCount-1:0]       validReg;
    logic [stageCount-1:0]       highReg;

    // both operands are signed, so this is a signed multiply
    assign product = operand.extA * operand.extB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validReg <= '0;
        end else begin
            validReg <= {validReg[stageCount-2:0], operand.valid};
        end
    end

    always_ff @(posedge clk) begin
        prodReg[0] <= product;
        tagReg[0]  <= operand.tag;
        highReg    <= {highReg[stageCount-2:0], operand.highHalf};
        for (int i = 1; i < stageCount; i++) begin
            prodReg[i] <= prodReg[i-1];
            tagReg[i]  <= tagReg[i-1];
        end
    end

    // queue write happens on the edge after the last stage
    assign push = validReg[last];

    always_comb begin
        pushData.tag  = tagReg[last];
        pushData.data = highReg[last] ? prodReg[last][2*`MUL_DATA_WIDTH-1:`MUL_DATA_WIDTH]
                                      : prodReg[last][`MUL_DATA_WIDTH-1:0];
    end

endmodule

`default_nettype wire

/* verilog/mulResultQueue.sv */
// In-order result queue
// Circular buffer of finished responses with an occupancy count

`timescale 1ns/1ps
`default_nettype none

`include "mulDefines.svh"

module mulResultQueue
    import mulFlowPkg::*;
#(
    parameter type payloadT = mulRspT,
    parameter int  depth = `MUL_QUEUE_DEPTH
) (
    input wire logic    clk,
    input wire logic    rstN,
    input wire logic    push,
    input wire payloadT pushData,
    input wire logic    pop,
    output logic        notEmpty,
    output payloadT     headData
);
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;

    typedef logic [ptrWidth-1:0] ptrT;
    typedef logic [$clog2(depth + 1)-1:0] countT;

    payloadT mem [depth];
    ptrT     rdPtr;
    ptrT     wrPtr;
    countT   count;

    function automatic ptrT nextPtr(input ptrT ptr);
        return (ptr == ptrT'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign notEmpty = (count != '0);
    assign headData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            count <= count + countT'(push) - countT'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= pushData;
    end

    // upstream credits must keep the queue from overflowing
    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        push |-> count < countT'(depth));
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> notEmpty);

endmodule

`default_nettype wire

/* verilog/mulFlowControl.sv */
// Multiply unit flow control
// Accepts requests against upstream credits, drains the result queue
// against downstream credits and returns an upstream credit per response

`timescale 1ns/1ps
`default_nettype none

`include "mulDefines.svh"

module mulFlowControl
    import mulOpPkg::*, mulFlowPkg::*;
(
    input wire logic    clk,
    input wire logic    rstN,
    input wire logic    reqValid,
    input wire mulOpT   reqOp,
    input wire mulTagT  reqTag,
    input wire mulDataT reqSrcA,
    input wire mulDataT reqSrcB,
    input wire logic    rspCredit,
    mulIssueIf.issuer   issue,
    input wire logic    notEmpty,
    input wire mulRspT  headData,
    output logic        pop,
    output logic        rspValid,
    output mulTagT      rspTag,
    output mulDataT     rspData,
    output logic        reqCredit
);
    creditCntT rspCreditCnt;
    // slots held by the issuer, in flight or queued
    creditCntT slotsCommitted;

    // slot was reserved by the issuer's credit, so accept right away
    assign issue.valid = reqValid;
    assign issue.op    = reqOp;
    assign issue.tag   = reqTag;
    assign issue.srcA  = reqSrcA;
    assign issue.srcB  = reqSrcB;

    assign pop = notEmpty && (rspCreditCnt != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rspValid       <= 1'b0;
            reqCredit      <= 1'b0;
            rspCreditCnt   <= creditCntT'(`MUL_RSP_CREDITS);
            slotsCommitted <= '0;
        end else begin
            rspValid       <= pop;
            reqCredit      <= pop;
            rspCreditCnt   <= rspCreditCnt + creditCntT'(rspCredit) - creditCntT'(pop);
            slotsCommitted <= slotsCommitted + creditCntT'(reqValid) - creditCntT'(reqCredit);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rspTag  <= headData.tag;
            rspData <= headData.data;
        end
    end

    noIssueWithoutCredit: assert property (@(posedge clk) disable iff (!rstN)
        reqValid |-> slotsCommitted < creditCntT'(`MUL_QUEUE_DEPTH));
    // consumer returns no more than it granted
    rspCreditBound: assert property (@(posedge clk) disable iff (!rstN)
        rspCredit |=> rspCreditCnt <= creditCntT'(`MUL_RSP_CREDITS));

endmodule

`default_nettype wire

/* verilog/mulExecUnit.sv */
// Integer multiply execution unit
// Credit-controlled MUL/MULH/MULHSU/MULHU pipeline with in-order results

`timescale 1ns/1ps
`default_nettype none

`include "mulDefines.svh"

module mulExecUnit
    import mulOpPkg::*, mulFlowPkg::*;
(
    input wire logic    clk,
    input wire logic    rstN,
    input wire logic    reqValid,
    input wire mulOpT   reqOp,
    input wire mulTagT  reqTag,
    input wire mulDataT reqSrcA,
    input wire mulDataT reqSrcB,
    output logic        reqCredit,
    output logic        rspValid,
    output mulTagT      rspTag,
    output mulDataT     rspData,
    input wire logic    rspCredit
);
    logic   push;
    logic   pop;
    logic   notEmpty;
    mulRspT pushData;
    mulRspT headData;

    mulIssueIf   issueBus ();
    mulOperandIf operandBus ();

    mulFlowControl flowControl (
        .clk, .rstN, .reqValid, .reqOp, .reqTag, .reqSrcA, .reqSrcB, .rspCredit,
        .issue(issueBus.issuer), .notEmpty, .headData, .pop,
        .rspValid, .rspTag, .rspData, .reqCredit
    );

    mulOperandPrep operandPrep (.clk, .rstN, .issue(issueBus.prep), .operand(operandBus.source));

    // prep register takes one of the MUL_PIPE_DEPTH cycles
    mulPipelinedCore #(.stageCount(`MUL_PIPE_DEPTH - 1)) pipelinedCore (
        .clk, .rstN, .operand(operandBus.sink), .push, .pushData
    );

    mulResultQueue #(.payloadT(mulRspT), .depth(`MUL_QUEUE_DEPTH)) resultQueue (
        .clk, .rstN, .push, .pushData, .pop, .notEmpty, .headData
    );

endmodule

`default_nettype wire

/* bench/mulExecUnitTb.sv */
// Multiply unit testbench
// Plays the upstream issuer and the downstream consumer around the DUT
// and checks results, order, credits, latency and reset behavior

`timescale 1ns/1ps
`default_nettype none

`include "mulDefines.svh"

module mulExecUnitTb
    import mulOpPkg::*, mulFlowPkg::*;
();
    localparam int vecCount = 32;
    localparam int quietCycles = 20;
    localparam int watchdogCycles = vecCount * (`MUL_PIPE_DEPTH + 8) * 8 + 8;

    logic    clk;
    logic    rstN;
    logic    reqValid;
    mulOpT   reqOp;
    mulTagT  reqTag;
    mulDataT reqSrcA;
    mulDataT reqSrcB;
    logic    reqCredit;
    logic    rspValid;
    mulTagT  rspTag;
    mulDataT rspData;
    logic    rspCredit;

    // op, tag, srcA, srcB, expected result
    logic [103:0] vecMem [0:vecCount-1];
    logic [35:0]  expQ [$];
    int           acceptQ [$];
    int           creditDueQ [$];
    int           cycleCnt, upCredit, downCredit, issuedCnt, rspCnt;
    int           mismatchCnt, otherCnt, lastDue, phaseIssued, phaseRsp;
    logic         withhold, quietWindow, lastRstN;
    logic [31:0]  lcgState;

    mulExecUnit DUT (
        .clk(clk), .rstN(rstN), .reqValid(reqValid), .reqOp(reqOp), .reqTag(reqTag),
        .reqSrcA(reqSrcA), .reqSrcB(reqSrcB), .reqCredit(reqCredit), .rspValid(rspValid),
        .rspTag(rspTag), .rspData(rspData), .rspCredit(rspCredit)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycleCnt++;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
            mismatchCnt++;
        end
    endtask

    task automatic flagError(input string what);
        $display("ERROR at %0t: %s", $time, what);
        otherCnt++;
    endtask

    // one issuer cycle that sends the next vector if a credit is left
    task automatic driveCycle(input logic allowIssue);
        logic [103:0] vec;
        @(posedge clk);
        #0.5;
        reqValid = 1'b0;
        if (allowIssue && upCredit > 0) begin
            vec = vecMem[issuedCnt % vecCount];
            reqOp = mulOpT'(vec[101:100]);
            reqTag = vec[99:96];
            reqSrcA = vec[95:64];
            reqSrcB = vec[63:32];
            reqValid = 1'b1;
            upCredit--;
            expQ.push_back({vec[99:96], vec[31:0]});
            acceptQ.push_back(cycleCnt + 1);
            issuedCnt++;
        end
        #1;
    endtask

    task automatic drain();
        while (expQ.size() != 0 || creditDueQ.size() != 0) driveCycle(1'b0);
    endtask

    // consumer hands back each credit when its delay has run out
    always @(posedge clk) begin
        #0.5;
        rspCredit = 1'b0;
        if (!withhold && creditDueQ.size() != 0 && creditDueQ[0] <= cycleCnt) begin
            void'(creditDueQ.pop_front());
            rspCredit = 1'b1;
            downCredit++;
        end
    end

    always @(negedge clk) begin : monitor
        logic [35:0] expRsp;
        int          latency;
        int          due;
        if (!rstN || !lastRstN) begin
            checkEq("rspValid", rspValid, 32'd0);
            checkEq("reqCredit", reqCredit, 32'd0);
        end else begin
            checkEq("reqCredit", reqCredit, rspValid);
            if (reqCredit) upCredit++;
            if (rspValid) begin
                if (expQ.size() == 0) begin
                    flagError("response arrived with no request outstanding");
                end else begin
                    expRsp = expQ.pop_front();
                    latency = cycleCnt - acceptQ.pop_front();
                    checkEq("rspTag", rspTag, expRsp[35:32]);
                    checkEq("rspData", rspData, expRsp[31:0]);
                    if (latency < `MUL_PIPE_DEPTH + 1) flagError("response came too early");
                    // first responses after reset see an empty queue and full credit
                    if (rspCnt < `MUL_RSP_CREDITS) begin
                        checkEq("rspLatency", latency, `MUL_PIPE_DEPTH + 1);
                    end
                end
                if (downCredit == 0) flagError("response sent without a downstream credit");
                else downCredit--;
                if (quietWindow) flagError("response sent while credits were withheld");
                rspCnt++;
                lcgState = lcgNext(lcgState);
                due = cycleCnt + 1 + int'(lcgState[30:28]);
                lastDue = (due > lastDue) ? due : lastDue + 1;
                creditDueQ.push_back(lastDue);
            end
        end
        lastRstN = rstN;
    end

    initial begin
        reqValid = 1'b0;
        reqOp = opMul;
        reqTag = '0;
        reqSrcA = '0;
        reqSrcB = '0;
        rspCredit = 1'b0;
        rstN = 1'b0;
        withhold = 1'b0;
        quietWindow = 1'b0;
        lastRstN = 1'b0;
        lcgState = 32'h62ce_d5cf;
        cycleCnt = 0;
        upCredit = `MUL_QUEUE_DEPTH;
        downCredit = `MUL_RSP_CREDITS;
        issuedCnt = 0;
        rspCnt = 0;
        mismatchCnt = 0;
        otherCnt = 0;
        lastDue = 0;
        $readmemh("bench/mulTestdata.txt", vecMem);
        repeat (8) @(posedge clk);
        #0.5;
        rstN = 1'b1;
        // every vector once with credits returned after random delays
        while (issuedCnt < vecCount) driveCycle(1'b1);
        drain();
        checkEq("upCredit", upCredit, `MUL_QUEUE_DEPTH);
        // consumer keeps all credits so the issuer runs dry
        withhold = 1'b1;
        phaseIssued = issuedCnt;
        phaseRsp = rspCnt;
        while (upCredit != 0 || downCredit != 0) driveCycle(1'b1);
        quietWindow = 1'b1;
        repeat (quietCycles) driveCycle(1'b1);
        quietWindow = 1'b0;
        checkEq("phaseResponses", rspCnt - phaseRsp, `MUL_RSP_CREDITS);
        checkEq("phaseOutstanding", (issuedCnt - phaseIssued) - (rspCnt - phaseRsp),
                `MUL_QUEUE_DEPTH);
        withhold = 1'b0;
        drain();
        checkEq("upCredit", upCredit, `MUL_QUEUE_DEPTH);
        checkEq("rspCount", rspCnt, issuedCnt);
        $display("errors: %0d value mismatches, %0d other failures", mismatchCnt, otherCnt);
        if (mismatchCnt + otherCnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", watchdogCycles);
        $display("errors: %0d value mismatches, %0d other failures", mismatchCnt, otherCnt + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mulExecUnit.f */
+incdir+verilog
verilog/mulOpPkg.sv
verilog/mulFlowPkg.sv
verilog/mulIssueIf.sv
verilog/mulOperandIf.sv
verilog/mulOperandPrep.sv
verilog/mulPipelinedCore.sv
verilog/mulResultQueue.sv
verilog/mulFlowControl.sv
verilog/mulExecUnit.sv
bench/mulExecUnitTb.sv

/* runSim.sh */
#!/bin/sh
# Build the multiply unit testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module mulExecUnitTb -f mulExecUnit.f \
    -o mulExecUnitTb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/mulExecUnitTb > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* bench/mulTestdata.txt */
// columns: op (1 digit), tag (1 digit), srcA (8), srcB (8), expected result (8)
// op: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU
00000000030000000700000015
01800000008000000000000000
02FFFFFFFFFFFFFFFF00000001
03000000001234567800000000
04000100000001000000000000
050000FFFF0000FFFFFFFE0001
06FFFFFFFF00000002FFFFFFFE
07123456780000001023456780
18800000008000000040000000
19FFFFFFFFFFFFFFFF00000000
1A00000000FFFFFFFF00000000
1B7FFFFFFF7FFFFFFF3FFFFFFF
1CFFFFFFFF00000001FFFFFFFF
1D800000007FFFFFFFC0000000
1E000100000001000000000001
1F8000000000000002FFFFFFFF
20FFFFFFFFFFFFFFFFFFFFFFFF
218000000080000000C0000000
2200000000FFFFFFFF00000000
237FFFFFFFFFFFFFFF7FFFFFFE
24FFFFFFFF00000002FFFFFFFF
25000000028000000000000001
2680000000FFFFFFFF80000000
27000100000001000000000001
38FFFFFFFFFFFFFFFFFFFFFFFE
39800000008000000040000000
3A00000000FFFFFFFF00000000
3BFFFFFFFF0000000200000001
3C800000000000000200000001
3D123456780000001000000001
3E0000FFFF0000FFFF00000000
3F7FFFFFFF0000000200000000
